//--- flist.f
+incdir+tb
rtl/rvcPkg.sv
rtl/compressedExpander.sv
rtl/fetchAligner.sv
rtl/instrQueue.sv
rtl/issueStage.sv
rtl/fetchFrontend.sv
tb/fetchFrontendTb.sv

//--- rtl/compressedExpander.sv
module compressedExpander (
  input  rvcPkg::instrWord raw,
  output rvcPkg::instrWord expanded,
  output logic             illegal
);
  import rvcPkg::*;

  halfWord     c;
  logic [2:0]  funct3;
  logic [4:0]  rdFull;
  logic [4:0]  rs2Full;
  logic [4:0]  rdPrime;
  logic [4:0]  rs1Prime;
  logic [4:0]  shamt;
  logic [11:0] immCi;
  logic [11:0] immAddi4spn;
  logic [11:0] immLw;
  logic [11:0] immAddi16sp;
  logic [11:0] immLwsp;
  logic [11:0] immSwsp;
  logic [19:0] immLui;
  logic [20:0] offJ;
  logic [12:0] offB;

  assign c        = raw[15:0];
  assign funct3   = c[15:13];
  assign rdFull   = c[11:7];
  assign rs2Full  = c[6:2];
  assign rdPrime  = {2'b01, c[4:2]};  // x8..x15
  assign rs1Prime = {2'b01, c[9:7]};
  assign shamt    = c[6:2];

  assign immCi       = {{6{c[12]}}, c[12], c[6:2]};
  assign immAddi4spn = {2'b00, c[10:7], c[12:11], c[5], c[6], 2'b00};
  assign immLw       = {5'b00000, c[5], c[12:10], c[6], 2'b00};
  assign immAddi16sp = {{3{c[12]}}, c[4:3], c[5], c[2], c[6], 4'b0000};
  assign immLwsp     = {4'b0000, c[3:2], c[12], c[6:4], 2'b00};
  assign immSwsp     = {4'b0000, c[8:7], c[12:9], 2'b00};
  assign immLui      = {{15{c[12]}}, c[6:2]};
  assign offJ        = {{10{c[12]}}, c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3], 1'b0};
  assign offB        = {{5{c[12]}}, c[6:5], c[2], c[11:10], c[4:3], 1'b0};

  always_comb begin
    expanded = '0;
    illegal  = 1'b0;
    if (c[1:0] == 2'b11) begin
      expanded = raw;  // Already 32-bit
    end else begin
      case (c[1:0])
        2'b00: begin
          case (funct3)
            3'b000: begin  // C.ADDI4SPN
              if (c[12:5] == 8'h00) begin
                illegal = 1'b1;  // Also catches the zero halfword
              end else begin
                expanded = {immAddi4spn, 5'd2, 3'b000, rdPrime, OP_IMM};
              end
            end
            3'b010: expanded = {immLw, rs1Prime, 3'b010, rdPrime, LOAD};  // C.LW
            3'b110: expanded = {immLw[11:5], rdPrime, rs1Prime, 3'b010, immLw[4:0], STORE};
            default: illegal = 1'b1;  // FP, RV64 and reserved slots
          endcase
        end
        2'b01: begin
          case (funct3)
            3'b000: expanded = {immCi, rdFull, 3'b000, rdFull, OP_IMM};  // C.ADDI, C.NOP
            3'b001, 3'b101: begin  // C.JAL links x1, C.J links x0
              expanded = {offJ[20], offJ[10:1], offJ[11], offJ[19:12],
                          {4'b0000, ~funct3[2]}, JAL};
            end
            3'b010: expanded = {immCi, 5'd0, 3'b000, rdFull, OP_IMM};  // C.LI
            3'b011: begin
              if ({c[12], c[6:2]} == 6'd0) begin
                illegal = 1'b1;
              end else if (rdFull == 5'd2) begin
                expanded = {immAddi16sp, 5'd2, 3'b000, 5'd2, OP_IMM};  // C.ADDI16SP
              end else begin
                expanded = {immLui, rdFull, LUI};  // C.LUI
              end
            end
            3'b100: begin
              case (c[11:10])
                2'b00, 2'b01: begin  // C.SRLI, C.SRAI
                  if (c[12]) begin
                    illegal = 1'b1;
                  end else begin
                    expanded = {1'b0, c[10], 5'b00000, shamt, rs1Prime, 3'b101,
                                rs1Prime, OP_IMM};
                  end
                end
                2'b10: expanded = {immCi, rs1Prime, 3'b111, rs1Prime, OP_IMM};  // C.ANDI
                default: begin
                  case ({c[12], c[6:5]})
                    3'b000: expanded = {7'b0100000, rdPrime, rs1Prime, 3'b000, rs1Prime, OP};
                    3'b001: expanded = {7'b0000000, rdPrime, rs1Prime, 3'b100, rs1Prime, OP};
                    3'b010: expanded = {7'b0000000, rdPrime, rs1Prime, 3'b110, rs1Prime, OP};
                    3'b011: expanded = {7'b0000000, rdPrime, rs1Prime, 3'b111, rs1Prime, OP};
                    default: illegal = 1'b1;  // C.SUBW, C.ADDW, reserved
                  endcase
                end
              endcase
            end
            default: begin  // C.BEQZ, C.BNEZ
              expanded = {offB[12], offB[10:5], 5'd0, rs1Prime, {2'b00, funct3[0]},
                          offB[4:1], offB[11], BRANCH};
            end
          endcase
        end
        default: begin  // Quadrant 2
          case (funct3)
            3'b000: begin  // C.SLLI
              if (c[12]) begin
                illegal = 1'b1;
              end else begin
                expanded = {7'b0000000, shamt, rdFull, 3'b001, rdFull, OP_IMM};
              end
            end
            3'b010: begin  // C.LWSP
              if (rdFull == 5'd0) begin
                illegal = 1'b1;
              end else begin
                expanded = {immLwsp, 5'd2, 3'b010, rdFull, LOAD};
              end
            end
            3'b100: begin
              if (rs2Full != 5'd0) begin
                // C.MV adds to x0, C.ADD to rd
                expanded = {7'b0000000, rs2Full, rdFull & {5{c[12]}}, 3'b000, rdFull, OP};
              end else if (rdFull != 5'd0) begin
                // C.JR links x0, C.JALR links x1
                expanded = {12'h000, rdFull, 3'b000, {4'b0000, c[12]}, JALR};
              end else if (c[12]) begin
                expanded = {12'h001, 5'd0, 3'b000, 5'd0, SYSTEM};  // C.EBREAK
              end else begin
                illegal = 1'b1;  // C.JR with rs1 zero
              end
            end
            3'b110: expanded = {immSwsp[11:5], rs2Full, 5'd2, 3'b010, immSwsp[4:0], STORE};
            default: illegal = 1'b1;  // FP and RV64 stack slots
          endcase
        end
      endcase
    end
  end

endmodule

//--- rtl/fetchAligner.sv
module fetchAligner #(
  parameter rvcPkg::pcAddr ResetPc = 32'h0000_0000
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              fetchValid,
  input  rvcPkg::instrWord  fetchWord,
  output logic [1:0]        wrCount,
  output rvcPkg::queueEntry wrEntry0,
  output rvcPkg::queueEntry wrEntry1
);
  import rvcPkg::*;

  alignState state;
  alignState stateNext;
  pcAddr     pc;
  pcAddr     pcNext;
  pcAddr     pcHigh;
  halfWord   leftover;
  halfWord   leftoverNext;
  halfWord   lowHalf;
  halfWord   highHalf;
  logic      lowIsComp;
  logic      highIsComp;
  logic [1:0] countNext;
  queueEntry entry0Next;
  queueEntry entry1Next;

  assign lowHalf    = fetchWord[15:0];
  assign highHalf   = fetchWord[31:16];
  assign lowIsComp  = lowHalf[1:0] != 2'b11;
  assign highIsComp = highHalf[1:0] != 2'b11;

  always_comb begin
    stateNext    = state;
    pcNext       = pc;
    leftoverNext = leftover;
    countNext    = 2'd0;
    entry0Next   = '0;
    entry1Next   = '0;
    pcHigh       = pc + 32'd2;
    if (fetchValid) begin
      if (state == EMPTY && !lowIsComp) begin
        countNext  = 2'd1;  // Aligned 32-bit word
        entry0Next = '{raw: fetchWord, pc: pc, isCompressed: 1'b0};
        pcNext     = pc + 32'd4;
      end else begin
        if (state == HAVE_HALF) begin
          // Held parcel is the low half, new low parcel the high half
          entry0Next = '{raw: {lowHalf, leftover}, pc: pc, isCompressed: 1'b0};
          pcHigh     = pc + 32'd4;
        end else begin
          entry0Next = '{raw: {16'h0000, lowHalf}, pc: pc, isCompressed: 1'b1};
        end
        if (highIsComp) begin
          countNext  = 2'd2;
          entry1Next = '{raw: {16'h0000, highHalf}, pc: pcHigh, isCompressed: 1'b1};
          pcNext     = pcHigh + 32'd2;
          stateNext  = EMPTY;
        end else begin
          countNext    = 2'd1;  // High parcel starts a straddler
          leftoverNext = highHalf;
          pcNext       = pcHigh;
          stateNext    = HAVE_HALF;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= EMPTY;
      pc      <= ResetPc;
      wrCount <= 2'd0;
    end else begin
      state   <= stateNext;
      pc      <= pcNext;
      wrCount <= countNext;
    end
  end

  always_ff @(posedge clk) begin
    leftover <= leftoverNext;
    wrEntry0 <= entry0Next;
    wrEntry1 <= entry1Next;
  end

endmodule

//--- rtl/fetchFrontend.sv
module fetchFrontend #(
  parameter rvcPkg::pcAddr ResetPc    = 32'h0000_0000,
  parameter int unsigned   QueueDepth = 8
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               fetchValid,
  input  rvcPkg::instrWord   fetchWord,
  output logic               instValid,
  output rvcPkg::issuedInstr inst,
  output logic               overflow
);
  import rvcPkg::*;

  logic [1:0] wrCount;
  queueEntry  wrEntry0;
  queueEntry  wrEntry1;
  queueEntry  head;
  logic       notEmpty;
  logic       pop;

  fetchAligner #(
    .ResetPc (ResetPc)
  ) i_fetchAligner (
    .clk        (clk),
    .rst        (rst),
    .fetchValid (fetchValid),
    .fetchWord  (fetchWord),
    .wrCount    (wrCount),
    .wrEntry0   (wrEntry0),
    .wrEntry1   (wrEntry1)
  );

  instrQueue #(
    .QueueDepth (QueueDepth)
  ) i_instrQueue (
    .clk      (clk),
    .rst      (rst),
    .wrCount  (wrCount),
    .wrEntry0 (wrEntry0),
    .wrEntry1 (wrEntry1),
    .pop      (pop),
    .notEmpty (notEmpty),
    .head     (head),
    .overflow (overflow)
  );

  issueStage i_issueStage (
    .clk       (clk),
    .rst       (rst),
    .notEmpty  (notEmpty),
    .head      (head),
    .pop       (pop),
    .instValid (instValid),
    .inst      (inst)
  );

endmodule

//--- rtl/instrQueue.sv
module instrQueue #(
  parameter int unsigned QueueDepth = 8
) (
  input  logic              clk,
  input  logic              rst,
  input  logic [1:0]        wrCount,
  input  rvcPkg::queueEntry wrEntry0,
  input  rvcPkg::queueEntry wrEntry1,
  input  logic              pop,
  output logic              notEmpty,
  output rvcPkg::queueEntry head,
  output logic              overflow
);
  import rvcPkg::*;

  localparam int unsigned PtrWidth = $clog2(QueueDepth);

  typedef logic [PtrWidth-1:0] slotIdx;
  typedef logic [PtrWidth:0]   slotCount;

  queueEntry  slots [QueueDepth];
  slotIdx     rdPtr;
  slotIdx     wrPtr;
  slotIdx     wrPtrNext;
  slotCount   count;
  slotCount   freeSlots;
  slotCount   wrRequest;
  logic       doPop;
  logic [1:0] accepted;

  assign doPop     = pop && (count != '0);
  // Slot freed by this cycle's pop is available to the write
  assign freeSlots = slotCount'(QueueDepth) - count + slotCount'(doPop);
  assign wrRequest = slotCount'(wrCount);
  assign accepted  = (wrRequest > freeSlots) ? freeSlots[1:0] : wrCount;
  assign wrPtrNext = wrPtr + slotIdx'(1);

  always_ff @(posedge clk) begin
    if (rst) begin
      rdPtr    <= '0;
      wrPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (doPop) begin
        rdPtr <= rdPtr + slotIdx'(1);
      end
      wrPtr <= wrPtr + slotIdx'(accepted);
      count <= count + slotCount'(accepted) - slotCount'(doPop);
      if (accepted != wrCount) begin
        overflow <= 1'b1;  // Sticky until reset
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accepted != 2'd0) begin
      slots[wrPtr] <= wrEntry0;
    end
    if (accepted == 2'd2) begin
      slots[wrPtrNext] <= wrEntry1;  // Younger entry in next slot
    end
  end

  assign notEmpty = count != '0;
  assign head     = slots[rdPtr];

endmodule

//--- rtl/issueStage.sv
module issueStage (
  input  logic               clk,
  input  logic               rst,
  input  logic               notEmpty,
  input  rvcPkg::queueEntry  head,
  output logic               pop,
  output logic               instValid,
  output rvcPkg::issuedInstr inst
);
  import rvcPkg::*;

  instrWord expanded;
  logic     illegal;

  // Nothing downstream can stall, so drain one entry per cycle
  assign pop = notEmpty;

  compressedExpander i_compressedExpander (
    .raw      (head.raw),
    .expanded (expanded),
    .illegal  (illegal)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      instValid <= 1'b0;
    end else begin
      instValid <= pop;  // One-cycle pulse per issued entry
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      inst.instr        <= expanded;
      inst.pc           <= head.pc;
      inst.isCompressed <= head.isCompressed;
      inst.illegal      <= illegal;
    end
  end

endmodule

//--- rtl/rvcPkg.sv
package rvcPkg;

  typedef logic [31:0] instrWord;  // Full instruction or fetch word
  typedef logic [15:0] halfWord;   // One 16-bit parcel
  typedef logic [31:0] pcAddr;     // Byte address

  // Compressed entries keep the upper half of raw at zero
  typedef struct packed {
    instrWord raw;
    pcAddr    pc;
    logic     isCompressed;
  } queueEntry;

  typedef struct packed {
    instrWord instr;         // Expanded RV32I encoding
    pcAddr    pc;
    logic     isCompressed;
    logic     illegal;
  } issuedInstr;

  // RV32I major opcodes targeted by the expander
  typedef enum logic [6:0] {
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    SYSTEM = 7'b1110011
  } rvcOpcode;

  typedef enum logic {
    EMPTY,      // No parcel carried over
    HAVE_HALF   // Low half of a straddling instruction held
  } alignState;

endpackage

//--- run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal --top-module fetchFrontendTb -f flist.f -o simFrontend
./obj_dir/simFrontend | tee sim.log
if grep -q '\*\* FAIL \*\*' sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
if ! grep -q '\*\* PASS \*\*' sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation finished cleanly"

//--- tb/rvcVectors.svh
`ifndef RVC_VECTORS_SVH
`define RVC_VECTORS_SVH

// Each row holds the encoding (a compressed parcel sits in the low half),
// the expected RV32I expansion and the expected illegal flag
typedef struct packed {
  logic [31:0] encoding;
  logic [31:0] expansion;
  logic        illegal;
} vecEntry;

localparam int NumVectors = 43;

localparam vecEntry VecTable [NumVectors] = '{
  '{32'h0000_0800, 32'h0101_0413, 1'b0},  // C.ADDI4SPN x8, 16
  '{32'h0000_4144, 32'h0045_2483, 1'b0},  // C.LW x9, 4(x10)
  '{32'h0000_C60C, 32'h00B6_2423, 1'b0},  // C.SW x11, 8(x12)
  '{32'h0000_0001, 32'h0000_0013, 1'b0},  // C.NOP
  '{32'h0000_157D, 32'hFFF5_0513, 1'b0},  // C.ADDI x10, -1
  '{32'h0000_2021, 32'h0080_00EF, 1'b0},  // C.JAL 8
  '{32'h0000_429D, 32'h0070_0293, 1'b0},  // C.LI x5, 7
  '{32'h0000_6105, 32'h0201_0113, 1'b0},  // C.ADDI16SP 32
  '{32'h0000_6185, 32'h0000_11B7, 1'b0},  // C.LUI x3, 1
  '{32'h0000_800D, 32'h0034_5413, 1'b0},  // C.SRLI x8, 3
  '{32'h0000_8491, 32'h4044_D493, 1'b0},  // C.SRAI x9, 4
  '{32'h0000_9979, 32'hFFE5_7513, 1'b0},  // C.ANDI x10, -2
  '{32'h0000_8C05, 32'h4094_0433, 1'b0},  // C.SUB x8, x9
  '{32'h0000_8CA9, 32'h00A4_C4B3, 1'b0},  // C.XOR x9, x10
  '{32'h0000_8D4D, 32'h00B5_6533, 1'b0},  // C.OR x10, x11
  '{32'h0000_8DF1, 32'h00C5_F5B3, 1'b0},  // C.AND x11, x12
  '{32'h0000_BFFD, 32'hFFFF_F06F, 1'b0},  // C.J -2
  '{32'h0000_C801, 32'h0004_0863, 1'b0},  // C.BEQZ x8, 16
  '{32'h0000_FCF5, 32'hFE04_9EE3, 1'b0},  // C.BNEZ x9, -4
  '{32'h0000_028A, 32'h0022_9293, 1'b0},  // C.SLLI x5, 2
  '{32'h0000_4332, 32'h00C1_2303, 1'b0},  // C.LWSP x6, 12
  '{32'h0000_8082, 32'h0000_8067, 1'b0},  // C.JR x1
  '{32'h0000_852E, 32'h00B0_0533, 1'b0},  // C.MV x10, x11
  '{32'h0000_9002, 32'h0010_0073, 1'b0},  // C.EBREAK
  '{32'h0000_9282, 32'h0002_80E7, 1'b0},  // C.JALR x5
  '{32'h0000_952E, 32'h00B5_0533, 1'b0},  // C.ADD x10, x11
  '{32'h0000_CA1E, 32'h0071_2A23, 1'b0},  // C.SWSP x7, 20
  '{32'h0000_0000, 32'h0000_0000, 1'b1},  // Zero halfword
  '{32'h0000_0004, 32'h0000_0000, 1'b1},  // C.ADDI4SPN zero imm
  '{32'h0000_2004, 32'h0000_0000, 1'b1},  // C.FLD
  '{32'h0000_6004, 32'h0000_0000, 1'b1},  // C.FLW
  '{32'h0000_8000, 32'h0000_0000, 1'b1},  // Reserved quadrant 0 slot
  '{32'h0000_6181, 32'h0000_0000, 1'b1},  // C.LUI zero imm
  '{32'h0000_6101, 32'h0000_0000, 1'b1},  // C.ADDI16SP zero imm
  '{32'h0000_900D, 32'h0000_0000, 1'b1},  // C.SRLI with shamt[5]
  '{32'h0000_9C05, 32'h0000_0000, 1'b1},  // C.SUBW, RV64 only
  '{32'h0000_8002, 32'h0000_0000, 1'b1},  // C.JR x0
  '{32'h0000_4002, 32'h0000_0000, 1'b1},  // C.LWSP x0
  '{32'h0000_E002, 32'h0000_0000, 1'b1},  // C.FSWSP
  '{32'h00A0_0093, 32'h00A0_0093, 1'b0},  // addi x1, x0, 10
  '{32'h0020_81B3, 32'h0020_81B3, 1'b0},  // add x3, x1, x2
  '{32'h0011_2623, 32'h0011_2623, 1'b0},  // sw x1, 12(x2)
  '{32'hFE1F_F06F, 32'hFE1F_F06F, 1'b0}   // jal x0, -32
};

`endif

//--- tb/fetchFrontendTb.sv
module fetchFrontendTb;
  timeunit 1ns;
  timeprecision 1ps;

  import rvcPkg::*;

  `include "rvcVectors.svh"

  localparam pcAddr   ResetPc     = 32'h0000_1000;
  localparam int      BurstWords  = 16;
  localparam int      ResetCycles = 10;
  localparam vecEntry NopEntry    = '{32'h0000_0001, 32'h0000_0013, 1'b0};

  logic       clk;
  logic       rst;
  logic       fetchValid;
  instrWord   fetchWord;
  logic       instValid;
  issuedInstr inst;
  logic       overflow;

  halfWord    parcels[$];     // Whole stream, both passes
  issuedInstr expQueue[$];
  int         wordEnd[2];     // Cumulative word count per pass
  int         expEnd[2];      // Cumulative instruction count per pass
  int         order[NumVectors];
  pcAddr      runPc;
  logic       straddleNext;
  logic       checking;
  integer     seed;
  int         cycleCount;
  int         cycleLimit;
  int         issuedCount;
  int         idleCycles;
  int         checkCount;
  int         errorCount;

  fetchFrontend #(
    .ResetPc    (ResetPc),
    .QueueDepth (8)
  ) i_fetchFrontend (
    .clk        (clk),
    .rst        (rst),
    .fetchValid (fetchValid),
    .fetchWord  (fetchWord),
    .instValid  (instValid),
    .inst       (inst),
    .overflow   (overflow)
  );

  always #4 clk = ~clk;  // 8 ns period

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic appendInstr(input vecEntry v);
    issuedInstr e;
    logic       isComp;
    isComp = v.encoding[1:0] != 2'b11;
    e = '{instr: v.expansion, pc: runPc, isCompressed: isComp, illegal: v.illegal};
    expQueue.push_back(e);
    parcels.push_back(v.encoding[15:0]);
    if (!isComp) begin
      parcels.push_back(v.encoding[31:16]);
    end
    runPc = runPc + (isComp ? 32'd2 : 32'd4);
  endtask

  task automatic buildPass(input int p);
    vecEntry v;
    for (int i = 0; i < NumVectors; i++) begin
      v = VecTable[order[i]];
      if (v.encoding[1:0] == 2'b11) begin
        // Alternate 32-bit entries between aligned and straddling
        if (parcels.size() % 2 != int'(straddleNext)) begin
          appendInstr(NopEntry);
        end
        straddleNext = !straddleNext;
      end
      appendInstr(v);
    end
    if (parcels.size() % 2 != 0) begin
      appendInstr(NopEntry);  // Fill last word
    end
    wordEnd[p] = parcels.size() / 2;
    expEnd[p]  = expQueue.size();
  endtask

  task automatic shuffleOrder();
    int j;
    int tmp;
    for (int i = NumVectors - 1; i > 0; i--) begin
      j        = $unsigned($random(seed)) % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
  endtask

  task automatic compareIssued();
    issuedInstr e;
    if (expQueue.size() == 0) begin
      errorCount++;
      $display("ERROR at %0t ns: an instruction issued after the expected stream ended", $time);
    end else begin
      e = expQueue.pop_front();
      checkValue("inst.instr", inst.instr, e.instr);
      checkValue("inst.pc", inst.pc, e.pc);
      checkValue("inst.isCompressed", 32'(inst.isCompressed), 32'(e.isCompressed));
      checkValue("inst.illegal", 32'(inst.illegal), 32'(e.illegal));
    end
  endtask

  task automatic runPass(input int p, input string label);
    int errorsBefore;
    int firstWord;
    int firstExp;
    errorsBefore = errorCount;
    firstWord    = (p == 0) ? 0 : wordEnd[0];
    firstExp     = (p == 0) ? 0 : expEnd[0];
    for (int w = firstWord; w < wordEnd[p]; w++) begin
      @(posedge clk);
      fetchValid <= 1'b1;
      fetchWord  <= {parcels[2*w+1], parcels[2*w]};
      @(posedge clk);
      fetchValid <= 1'b0;  // One word every two cycles
    end
    while (issuedCount < expEnd[p]) @(posedge clk);
    @(negedge clk);
    checkValue("overflow", 32'(overflow), 32'd0);
    $display("Test %s: %0d instructions, %0d errors", label, expEnd[p] - firstExp,
             errorCount - errorsBefore);
  endtask

  task automatic runBurst();
    int errorsBefore;
    errorsBefore = errorCount;
    @(posedge clk);
    rst <= 1'b1;
    repeat (ResetCycles) @(posedge clk);
    rst        <= 1'b0;
    checking    = 1'b0;
    issuedCount = 0;
    repeat (BurstWords) begin
      fetchValid <= 1'b1;
      fetchWord  <= {NopEntry.encoding[15:0], NopEntry.encoding[15:0]};
      @(posedge clk);
    end
    fetchValid <= 1'b0;
    idleCycles  = 0;
    while (idleCycles < 2) @(posedge clk);  // Queue drained
    @(negedge clk);
    checkValue("overflow", 32'(overflow), 32'd1);
    if (issuedCount > 2 * BurstWords) begin
      errorCount++;
      $display("ERROR at %0t ns: burst issued %0d instructions but only %0d were sent",
               $time, issuedCount, 2 * BurstWords);
    end
    @(posedge clk);
    rst <= 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    checkValue("overflow", 32'(overflow), 32'd0);  // Cleared only by reset
    $display("Test 3 (overflow burst): %0d instructions, %0d errors", issuedCount,
             errorCount - errorsBefore);
  endtask

  // Monitor samples mid-cycle, away from the DUT's clock edge
  always @(negedge clk) begin
    if (!rst && instValid) begin
      issuedCount++;
      idleCycles = 0;
      if (checking) begin
        compareIssued();
      end
    end else begin
      idleCycles++;
    end
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
      $display("Run timed out after %0d cycles with issued instructions still missing",
               cycleCount);
      $display("** FAIL **");
      $finish;
    end
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    fetchValid   = 1'b0;
    fetchWord    = '0;
    seed         = 32'heb75_49e0;
    checking     = 1'b1;
    runPc        = ResetPc;
    straddleNext = 1'b1;
    cycleCount   = 0;
    cycleLimit   = 0;
    issuedCount  = 0;
    idleCycles   = 0;
    checkCount   = 0;
    errorCount   = 0;
    for (int i = 0; i < NumVectors; i++) begin
      order[i] = i;
    end
    buildPass(0);
    shuffleOrder();
    buildPass(1);
    // Two cycles per word plus burst and resets, four times over
    cycleLimit = 4 * (2 * wordEnd[1] + BurstWords + 3 * ResetCycles) + 100;
    repeat (ResetCycles) @(posedge clk);
    rst <= 1'b0;
    runPass(0, "1 (table in order)");
    runPass(1, "2 (table shuffled)");
    runBurst();
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
